/* Bender.yml */
package:
  name: cpu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - fetch/cpu_fetch.sv
      - fetch/cpu_opqueue.sv
      - exec/cpu_regs.sv
      - exec/cpu_exec.sv
      - source/cpu_top.sv
  - target: test
    include_dirs:
      - common
      - verif
    files:
      - verif/tb_cpu.sv

/* common/cpu_pkg.sv */
// cpu_pkg: word types, opcode enumeration and the two-way instruction union
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_ADDR_W-1:0] addr_t;
    typedef logic [`CPU_DATA_W-1:0] word_t;
    typedef logic [2:0]             reg_idx_t;

    // codes 10..15 are left free and run as NOP
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        LDI  = 4'd1,
        ADDI = 4'd2,
        MOV  = 4'd3,
        ADD  = 4'd4,
        SUB  = 4'd5,
        AND  = 4'd6,
        OR   = 4'd7,
        XOR  = 4'd8,
        OUT  = 4'd9
    } opcode_e;

    // register form: dst op= src
    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   dst;
        reg_idx_t   src;
        logic [5:0] pad;
    } instr_reg_t;

    // immediate form, imm is two's complement
    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   dst;
        logic [8:0] imm;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t rg;
        instr_imm_t im;
    } instr_u;

endpackage

`default_nettype wire

/* common/cpu_settings.svh */
// cpu settings: bus widths, opcode queue depth and program counter reset value
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// memory address width
`define CPU_ADDR_W 24

// data word and instruction width
`define CPU_DATA_W 16

// opcode queue entries, a power of two (2, 4, 8 or 16)
`define CPU_QDEPTH 4

// first fetch address after reset
`define CPU_PC_RSTVAL 0

`endif

/* exec/cpu_exec.sv */
// cpu_exec: instruction decode, ALU, register writeback and OUT strobe
`default_nettype none

`include "cpu_settings.svh"

module cpu_exec (
    input  logic              clk,
    input  logic              reset,
    input  logic              cen,
    input  cpu_pkg::word_t    head,
    input  logic              valid,
    output logic              pop,
    output logic              out_valid,
    output cpu_pkg::reg_idx_t out_reg,
    output cpu_pkg::word_t    out_data,
    input  cpu_pkg::reg_idx_t dmp_addr,
    output cpu_pkg::word_t    dmp_dout
);

    cpu_pkg::instr_u  ins;
    cpu_pkg::opcode_e opc;
    cpu_pkg::word_t   rd_a;
    cpu_pkg::word_t   rd_b;
    cpu_pkg::word_t   imm_ext;
    cpu_pkg::word_t   operand;
    cpu_pkg::word_t   alu_res;
    logic             use_imm;
    logic             wr_en;
    logic             is_out;

    // one instruction per enabled cycle
    assign pop = valid && cen;

    assign ins     = head;
    assign opc     = ins.rg.opcode;
    assign use_imm = (opc == cpu_pkg::LDI) || (opc == cpu_pkg::ADDI);
    assign is_out  = opc == cpu_pkg::OUT;
    assign imm_ext = {{(`CPU_DATA_W - 9){ins.im.imm[8]}}, ins.im.imm};
    assign operand = use_imm ? imm_ext : rd_b;

    always_comb begin
        wr_en   = 1'b1;
        alu_res = rd_a;
        case (opc)
            cpu_pkg::LDI,
            cpu_pkg::MOV:  alu_res = operand;
            cpu_pkg::ADDI,
            cpu_pkg::ADD:  alu_res = rd_a + operand;
            cpu_pkg::SUB:  alu_res = rd_a - operand;
            cpu_pkg::AND:  alu_res = rd_a & operand;
            cpu_pkg::OR:   alu_res = rd_a | operand;
            cpu_pkg::XOR:  alu_res = rd_a ^ operand;
            // NOP, OUT and unused codes leave the bank alone
            default:       wr_en = 1'b0;
        endcase
    end

    cpu_regs u_regs (
        .clk      ( clk          ),
        .reset    ( reset        ),
        .cen      ( cen          ),
        .rd_a_idx ( ins.rg.dst   ),
        .rd_b_idx ( ins.rg.src   ),
        .rd_a     ( rd_a         ),
        .rd_b     ( rd_b         ),
        .we       ( pop && wr_en ),
        .wr_idx   ( ins.rg.dst   ),
        .wr_data  ( alu_res      ),
        .dmp_addr ( dmp_addr     ),
        .dmp_dout ( dmp_dout     )
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (cen) begin
            out_valid <= pop && is_out;
        end
    end

    // value as read at the pop edge
    always_ff @(posedge clk) begin
        if (cen && pop && is_out) begin
            out_reg  <= ins.rg.dst;
            out_data <= rd_a;
        end
    end

    // a popped word must come from a filled queue slot
    a_head_known: assert property (@(posedge clk) disable iff (reset)
        pop |-> !$isunknown(head));

endmodule

`default_nettype wire

/* exec/cpu_regs.sv */
// cpu_regs: eight-entry register bank, two operand read ports, one write port, dump port
`default_nettype none

module cpu_regs (
    input  logic              clk,
    input  logic              reset,
    input  logic              cen,
    input  cpu_pkg::reg_idx_t rd_a_idx,
    input  cpu_pkg::reg_idx_t rd_b_idx,
    output cpu_pkg::word_t    rd_a,
    output cpu_pkg::word_t    rd_b,
    input  logic              we,
    input  cpu_pkg::reg_idx_t wr_idx,
    input  cpu_pkg::word_t    wr_data,
    input  cpu_pkg::reg_idx_t dmp_addr,
    output cpu_pkg::word_t    dmp_dout
);

    cpu_pkg::word_t regs [8];

    // all reads are combinational
    assign rd_a     = regs[rd_a_idx];
    assign rd_b     = regs[rd_b_idx];
    assign dmp_dout = regs[dmp_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (cen && we) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* fetch/cpu_fetch.sv */
// cpu_fetch: program counter and single-outstanding memory read requests
`default_nettype none

`include "cpu_settings.svh"

module cpu_fetch (
    input  logic           clk,
    input  logic           reset,
    input  logic           cen,
    input  logic           free,
    output logic           mem_rd,
    output cpu_pkg::addr_t mem_addr,
    input  logic           mem_ok,
    input  cpu_pkg::word_t mem_din,
    output logic           push,
    output cpu_pkg::word_t push_data
);

    cpu_pkg::addr_t pc;
    // high from the edge after mem_rd until mem_ok
    logic           pending;

    assign mem_addr  = pc;

    // returning word goes straight into the queue
    assign push      = mem_ok;
    assign push_data = mem_din;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= cpu_pkg::addr_t'(`CPU_PC_RSTVAL);
            pending <= 1'b0;
            mem_rd  <= 1'b0;
        end else if (cen) begin
            // a free slot now is still free when the word comes back,
            // only pops happen in between
            mem_rd <= free && !pending && !mem_rd;
            if (mem_rd) begin
                pending <= 1'b1;
            end
            if (mem_ok) begin
                pending <= 1'b0;
                // 24-bit wrap
                pc      <= pc + 1'b1;
            end
        end
    end

    // memory side must not answer a read that was never made
    a_ok_pending: assert property (@(posedge clk) disable iff (reset)
        mem_ok |-> pending);

    // one read in flight at most
    a_rd_single: assert property (@(posedge clk) disable iff (reset)
        mem_rd |-> !pending);

endmodule

`default_nettype wire

/* fetch/cpu_opqueue.sv */
// cpu_opqueue: circular opcode FIFO between fetch and execute, with free-slot flag
`default_nettype none

`include "cpu_settings.svh"

module cpu_opqueue (
    input  logic           clk,
    input  logic           reset,
    input  logic           cen,
    input  logic           push,
    input  cpu_pkg::word_t push_data,
    input  logic           pop,
    output cpu_pkg::word_t head,
    output logic           valid,
    output logic           free
);

    localparam int PTR_W = $clog2(`CPU_QDEPTH);
    localparam int CNT_W = $clog2(`CPU_QDEPTH + 1);

    cpu_pkg::word_t   mem [`CPU_QDEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head  = mem[rd_ptr];
    assign valid = count != '0;
    assign free  = count != CNT_W'(`CPU_QDEPTH);

    // entry storage
    always_ff @(posedge clk) begin
        if (cen && push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap at the power-of-two depth
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (cen) begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        cen && push |-> free);

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        cen && pop |-> valid);

endmodule

`default_nettype wire

/* source/cpu_top.sv */
// cpu_top: fetch unit, opcode queue and execute unit wired together
`default_nettype none

module cpu_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              cen,
    // memory read bus
    output logic              mem_rd,
    output cpu_pkg::addr_t    mem_addr,
    input  logic              mem_ok,
    input  cpu_pkg::word_t    mem_din,
    // output port
    output logic              out_valid,
    output cpu_pkg::reg_idx_t out_reg,
    output cpu_pkg::word_t    out_data,
    // register dump
    input  cpu_pkg::reg_idx_t dmp_addr,
    output cpu_pkg::word_t    dmp_dout
);

    logic           free;
    logic           push;
    cpu_pkg::word_t push_data;
    logic           pop;
    cpu_pkg::word_t head;
    logic           valid;

    cpu_fetch u_fetch (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .free      ( free      ),
        .mem_rd    ( mem_rd    ),
        .mem_addr  ( mem_addr  ),
        .mem_ok    ( mem_ok    ),
        .mem_din   ( mem_din   ),
        .push      ( push      ),
        .push_data ( push_data )
    );

    cpu_opqueue u_opqueue (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .push      ( push      ),
        .push_data ( push_data ),
        .pop       ( pop       ),
        .head      ( head      ),
        .valid     ( valid     ),
        .free      ( free      )
    );

    cpu_exec u_exec (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .head      ( head      ),
        .valid     ( valid     ),
        .pop       ( pop       ),
        .out_valid ( out_valid ),
        .out_reg   ( out_reg   ),
        .out_data  ( out_data  ),
        .dmp_addr  ( dmp_addr  ),
        .dmp_dout  ( dmp_dout  )
    );

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
+incdir+verif
common/cpu_pkg.sv
fetch/cpu_fetch.sv
fetch/cpu_opqueue.sv
exec/cpu_regs.sv
exec/cpu_exec.sv
source/cpu_top.sv
verif/tb_cpu.sv

/* verif/tb_cpu_model.svh */
// testbench model: LFSR source, program image generation and reference executor
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

// Galois LFSR, one step per bit handed out
function automatic logic [31:0] next_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        val = {val[30:0], lsb};
    end
    return val;
endfunction

// random words, every eighth one an OUT, words 56..62 only NOP or unused codes
function automatic void fill_program();
    cpu_pkg::instr_u ins;
    logic [2:0]      k;
    for (int a = 0; a < 64; a++) begin
        ins = cpu_pkg::word_t'(next_bits(16));
        if (a % 8 == 7) begin
            ins.rg.opcode = cpu_pkg::OUT;
        end else if (a >= 56) begin
            k = 3'(next_bits(3));
            ins.rg.opcode = (k < 2) ? cpu_pkg::NOP : cpu_pkg::opcode_e'(4'(8 + k));
        end
        prog[a] = ins;
    end
endfunction

// runs the word at the model PC, returns 1 for OUT
function automatic logic exec_next();
    cpu_pkg::instr_u ins;
    cpu_pkg::word_t  d;
    cpu_pkg::word_t  s;
    cpu_pkg::word_t  imm;
    ins = prog[(`CPU_PC_RSTVAL + model_pc) % 64];
    model_pc++;
    d   = model_regs[ins.im.dst];
    s   = model_regs[ins.rg.src];
    imm = cpu_pkg::word_t'($signed(ins.im.imm));
    case (ins.rg.opcode)
        cpu_pkg::LDI:  model_regs[ins.im.dst] = imm;
        cpu_pkg::ADDI: model_regs[ins.im.dst] = d + imm;
        cpu_pkg::MOV:  model_regs[ins.rg.dst] = s;
        cpu_pkg::ADD:  model_regs[ins.rg.dst] = d + s;
        cpu_pkg::SUB:  model_regs[ins.rg.dst] = d - s;
        cpu_pkg::AND:  model_regs[ins.rg.dst] = d & s;
        cpu_pkg::OR:   model_regs[ins.rg.dst] = d | s;
        cpu_pkg::XOR:  model_regs[ins.rg.dst] = d ^ s;
        default: ;
    endcase
    return ins.rg.opcode == cpu_pkg::OUT;
endfunction

// program words needed until n OUTs have run
function automatic int instrs_for_outs(input int n);
    cpu_pkg::instr_u ins;
    int              outs;
    int              cnt;
    outs = 0;
    cnt  = 0;
    while (outs < n) begin
        ins = prog[(`CPU_PC_RSTVAL + cnt) % 64];
        if (ins.rg.opcode == cpu_pkg::OUT) begin
            outs++;
        end
        cnt++;
    end
    return cnt;
endfunction

`endif

/* verif/tb_cpu.sv */
// tb_cpu: testbench top with clock, reset, memory responder, clock enable driver and checks
`default_nettype none

`include "cpu_settings.svh"

module tb_cpu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_OUTS  = 300;
    localparam int BP_AT     = 100;
    localparam int BP_CYCLES = 20;
    localparam int DRAIN     = 16;

    logic              clk;
    logic              reset;
    logic              cen;
    logic              mem_rd;
    cpu_pkg::addr_t    mem_addr;
    logic              mem_ok;
    cpu_pkg::word_t    mem_din;
    logic              out_valid;
    cpu_pkg::reg_idx_t out_reg;
    cpu_pkg::word_t    out_data;
    cpu_pkg::reg_idx_t dmp_addr;
    cpu_pkg::word_t    dmp_dout;

    logic [31:0]       lfsr;
    cpu_pkg::word_t    prog [64];
    cpu_pkg::word_t    model_regs [8];
    int                model_pc;
    // memory responder and run control
    logic              rd_pending;
    cpu_pkg::addr_t    req_addr;
    logic [1:0]        delay;
    int                words;
    int                out_count;
    int                cycles;
    int                cycle_limit;
    int                err_count;
    int                bp_left;
    logic              bp_watch;
    logic              bp_rd;
    int                drain;

    `include "tb_cpu_model.svh"

    cpu_top i_cpu_top (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .cen       ( cen       ),
        .mem_rd    ( mem_rd    ),
        .mem_addr  ( mem_addr  ),
        .mem_ok    ( mem_ok    ),
        .mem_din   ( mem_din   ),
        .out_valid ( out_valid ),
        .out_reg   ( out_reg   ),
        .out_data  ( out_data  ),
        .dmp_addr  ( dmp_addr  ),
        .dmp_dout  ( dmp_dout  )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure();
        err_count++;
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_addr(input string name, input cpu_pkg::addr_t exp,
                              input cpu_pkg::addr_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_word(input string name, input cpu_pkg::word_t exp,
                              input cpu_pkg::word_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h actual %h", name, exp, act);
            report_failure();
        end
    endtask

    task automatic check_reg(input string name, input cpu_pkg::reg_idx_t exp,
                             input cpu_pkg::reg_idx_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %0d actual %0d", name, exp, act);
            report_failure();
        end
    endtask

    // cen must be low while this runs
    task automatic check_dump(input string phase);
        for (int i = 0; i < 8; i++) begin
            dmp_addr = cpu_pkg::reg_idx_t'(i);
            #1;
            check_word($sformatf("%s r%0d", phase, i), model_regs[i], dmp_dout);
        end
    endtask

    // after 300 OUTs, stop feeding once the NOP stretch has gone in
    function automatic logic delivery_halted();
        return out_count >= NUM_OUTS && ((`CPU_PC_RSTVAL + words) % 64) == 63;
    endfunction

    // looks at the DUT as it was just before this edge
    task automatic observe();
        cpu_pkg::instr_u ins;
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Run did not finish within %0d cycles, %0d OUT strobes seen",
                     cycle_limit, out_count);
            report_failure();
        end
        if (bp_watch && mem_rd && !bp_rd) begin
            $display("A memory read appeared while the clock enable was held low");
            report_failure();
        end
        if (cen) begin
            if (mem_ok) begin
                rd_pending = 1'b0;
                words++;
            end
            if (mem_rd) begin
                if (rd_pending) begin
                    $display("A second memory read was issued before the first was answered");
                    report_failure();
                end
                check_addr("fetch order", cpu_pkg::addr_t'(`CPU_PC_RSTVAL + words), mem_addr);
                rd_pending = 1'b1;
                req_addr   = mem_addr;
                delay      = 2'(next_bits(2));
            end
            if (out_valid) begin
                ins = prog[(`CPU_PC_RSTVAL + model_pc) % 64];
                while (!exec_next()) begin
                    ins = prog[(`CPU_PC_RSTVAL + model_pc) % 64];
                end
                if (model_pc > words) begin
                    $display("out_valid came before its OUT instruction was fetched");
                    report_failure();
                end
                check_reg("output register", ins.rg.dst, out_reg);
                check_word("output data", model_regs[ins.rg.dst], out_data);
                out_count++;
                if (out_count == BP_AT) begin
                    bp_left = BP_CYCLES;
                end
            end
        end
    endtask

    // next cycle's inputs, 1 ns after the edge
    task automatic drive();
        mem_ok   = 1'b0;
        bp_watch = 1'b0;
        if (bp_left > 0) begin
            if (bp_left == BP_CYCLES) begin
                bp_rd = mem_rd;
            end
            bp_left--;
            bp_watch = 1'b1;
            cen      = 1'b0;
        end else if (delivery_halted()) begin
            drain++;
            cen = drain < DRAIN;
        end else begin
            // enabled in three of four cycles
            cen = next_bits(2) != 0;
        end
        if (rd_pending && delay == 0 && cen && !delivery_halted()) begin
            mem_ok  = 1'b1;
            mem_din = prog[req_addr[5:0]];
        end else if (rd_pending && delay != 0) begin
            delay--;
        end
    endtask

    initial begin
        reset      = 1'b1;
        cen        = 1'b0;
        mem_ok     = 1'b0;
        mem_din    = '0;
        dmp_addr   = '0;
        lfsr       = 32'd74300;
        rd_pending = 1'b0;
        req_addr   = '0;
        delay      = '0;
        words      = 0;
        out_count  = 0;
        cycles     = 0;
        err_count  = 0;
        bp_left    = 0;
        bp_watch   = 1'b0;
        bp_rd      = 1'b0;
        drain      = 0;
        model_pc   = 0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        fill_program();
        // 6 cycles per word, cen rate 3/4, margin 2, plus one image to reach the stretch
        cycle_limit = (instrs_for_outs(NUM_OUTS) + 64) * 16 + 100;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        if (mem_rd !== 1'b0 || out_valid !== 1'b0) begin
            $display("mem_rd or out_valid is not low after reset");
            report_failure();
        end
        check_dump("reset dump");
        while (drain < DRAIN) begin
            @(posedge clk);
            observe();
            #1;
            drive();
        end
        // every delivered word has left the queue, catch the model up
        while (model_pc < words) begin
            if (exec_next()) begin
                $display("An OUT instruction ran without an out_valid strobe");
                report_failure();
            end
        end
        check_dump("final dump");
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
